/* verilog.f */
src/swarm_types_pkg.sv
src/tsb_regs_pkg.sv
src/tsb_config.sv
src/tsb_entry_store.sv
src/tsb_lvt_scan.sv
src/tsb_ctrl.sv
src/tsb_top.sv
tb/tsb_props.sv
tb/tsb_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tsb_tb
FILELIST = verilog.f
LOG      = sim.log
FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tb/tsb_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module tsb_tb
   import swarm_types_pkg::*, tsb_regs_pkg::*;
;

   localparam int LOG_TSB_SIZE = 4;
   localparam int N_ENTRIES    = 2**LOG_TSB_SIZE;
   localparam int MAX_CYCLES   = 4000;   // Far above the length of the tests with random stalls

   typedef struct packed {
      task_t          t;
      logic           tied;
      tile_id_t       dest;
      logic           is_retry;
      tsb_entry_id_t  id;
      cq_slice_slot_t cq;
      child_id_t      child;
   } enq_exp_t;

   typedef struct packed {
      logic           ack;
      tsb_entry_id_t  id;
      epoch_t         epoch;
      tq_slot_t       tq;
      tile_id_t       tile;
      cq_slice_slot_t cq;
      child_id_t      child;
   } resp_exp_t;

   logic clk, rstn, s_wvalid, s_wready, s_tied, retry_valid, retry_ready, retry_abort, retry_tied;
   task_t s_wdata, task_enq_data;
   cq_slice_slot_t s_cq_slot, m_cq_slot;
   child_id_t s_child_id, m_child_id;
   tsb_entry_id_t retry_tsb_id, task_enq_tsb_id, task_resp_tsb_id, m_tsb_slot;
   logic task_enq_valid, task_enq_ready, task_enq_tied, task_resp_valid, task_resp_ready;
   logic task_resp_ack, m_resp_valid, m_resp_ready, m_resp_ack;
   tile_id_t task_enq_dest_tile, m_tile_id;
   epoch_t task_resp_epoch, m_epoch;
   tq_slot_t task_resp_tq_slot, m_tq_slot;
   logic reg_wvalid, reg_arvalid, reg_rvalid, s_only_untied, empty;
   reg_addr_t reg_waddr, reg_araddr;
   reg_data_t reg_wdata, reg_rdata;
   ts_t lvt;

   logic mdl_valid [N_ENTRIES];
   logic mdl_tied [N_ENTRIES];
   task_t mdl_task [N_ENTRIES];
   tile_id_t mdl_tile [N_ENTRIES];
   cq_slice_slot_t mdl_cq [N_ENTRIES];
   child_id_t mdl_child [N_ENTRIES];
   enq_exp_t enq_q[$];
   resp_exp_t resp_q[$];
   int n_errors = 0;
   int cycle_count = 0;
   int cur_log_n = 2;   // log2 of N_TILES after reset
   integer seed;
   logic stall_en = 1'b0;

   tsb_top #(.LOG_TSB_SIZE(LOG_TSB_SIZE), .N_TILES(4)) tsb_inst (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", MAX_CYCLES);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   always @(posedge clk) begin
      #1;
      task_enq_ready = stall_en ? 1'($random(seed)) : 1'b1;
      m_resp_ready   = stall_en ? 1'($random(seed)) : 1'b1;
   end

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (exp == act) else begin
         $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp, act);
         n_errors++;
      end
   endtask

   function automatic tile_id_t expected_dest(input hint_t h);
      int bits;
      bits = (cur_log_n > 4) ? 4 : cur_log_n;
      return tile_id_t'((h >> 4) & ((1 << bits) - 1));
   endfunction

   function automatic int count_valid();
      int n;
      n = 0;
      for (int i = 0; i < N_ENTRIES; i++) begin
         n += mdl_valid[i];
      end
      return n;
   endfunction

   function automatic ts_t min_ts();
      ts_t m;
      m = '1;
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (mdl_valid[i] && mdl_task[i].ts < m) begin
            m = mdl_task[i].ts;
         end
      end
      return m;
   endfunction

   // The shadow model learns entry ids from enqueue transfers
   always @(posedge clk) begin
      enq_exp_t e;
      if (rstn && task_enq_valid && task_enq_ready) begin
         if (enq_q.size() == 0) begin
            $display("Enqueue transfer at %0t without an accepted write or retry", $time);
            n_errors++;
         end else begin
            e = enq_q.pop_front();
            check_value("task_enq_data", e.t, task_enq_data);
            check_value("task_enq_tied", e.tied, task_enq_tied);
            check_value("task_enq_dest_tile", e.dest, task_enq_dest_tile);
            if (e.is_retry) begin
               check_value("task_enq_tsb_id", e.id, task_enq_tsb_id);
            end else begin
               check_value("task_enq_tsb_id in use", 0, mdl_valid[task_enq_tsb_id]);
               mdl_valid[task_enq_tsb_id] = 1'b1;
               mdl_tied[task_enq_tsb_id]  = e.tied;
               mdl_task[task_enq_tsb_id]  = e.t;
               mdl_tile[task_enq_tsb_id]  = e.dest;
               mdl_cq[task_enq_tsb_id]    = e.cq;
               mdl_child[task_enq_tsb_id] = e.child;
            end
         end
      end
   end

   always @(posedge clk) begin
      resp_exp_t r;
      if (rstn && m_resp_valid && m_resp_ready) begin
         if (resp_q.size() == 0) begin
            $display("Child response at %0t for an untied or unknown entry", $time);
            n_errors++;
         end else begin
            r = resp_q.pop_front();
            check_value("m_resp_ack", r.ack, m_resp_ack);
            check_value("m_tsb_slot", r.id, m_tsb_slot);
            check_value("m_epoch", r.epoch, m_epoch);
            check_value("m_tq_slot", r.tq, m_tq_slot);
            check_value("m_tile_id", r.tile, m_tile_id);
            check_value("m_cq_slot", r.cq, m_cq_slot);
            check_value("m_child_id", r.child, m_child_id);
         end
      end
   end

   task automatic send_write(input logic tied);
      enq_exp_t e;
      s_wdata    = {32'($random(seed)), 16'($random(seed)), 16'($random(seed))};
      s_tied     = tied;
      s_cq_slot  = 5'($random(seed));
      s_child_id = 2'($random(seed));
      s_wvalid   = 1'b1;
      @(posedge clk);
      while (!s_wready) @(posedge clk);
      e = {s_wdata, tied, expected_dest(s_wdata.hint), 1'b0, 4'd0, s_cq_slot, s_child_id};
      enq_q.push_back(e);
      #1 s_wvalid = 1'b0;
   endtask

   task automatic send_retry(input int id, input logic abort, input logic tied);
      retry_tsb_id = tsb_entry_id_t'(id);
      retry_abort  = abort;
      retry_tied   = tied;
      retry_valid  = 1'b1;
      @(posedge clk);
      while (!retry_ready) @(posedge clk);
      if (abort) begin
         mdl_valid[id] = 1'b0;
      end else begin
         enq_q.push_back({mdl_task[id], tied, mdl_tile[id], 1'b1, tsb_entry_id_t'(id),
                          mdl_cq[id], mdl_child[id]});
         mdl_tied[id] = tied;
      end
      #1 retry_valid = 1'b0;
   endtask

   task automatic send_resp(input int id, input logic ack);
      task_resp_tsb_id  = tsb_entry_id_t'(id);
      task_resp_ack     = ack;
      task_resp_epoch   = 8'($random(seed));
      task_resp_tq_slot = 6'($random(seed));
      task_resp_valid   = 1'b1;
      @(posedge clk);
      while (!task_resp_ready) @(posedge clk);
      if (mdl_tied[id]) begin
         resp_q.push_back({ack, tsb_entry_id_t'(id), task_resp_epoch, task_resp_tq_slot,
                           mdl_tile[id], mdl_cq[id], mdl_child[id]});
      end
      if (ack) mdl_valid[id] = 1'b0;
      #1 task_resp_valid = 1'b0;
   endtask

   task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
      reg_waddr  = addr;
      reg_wdata  = data;
      reg_wvalid = 1'b1;
      @(posedge clk);
      #1 reg_wvalid = 1'b0;
   endtask

   task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
      reg_araddr  = addr;
      reg_arvalid = 1'b1;
      @(posedge clk);
      #1 reg_arvalid = 1'b0;
      @(posedge clk);
      check_value("reg_rvalid", 1, reg_rvalid);
      data = reg_rdata;
      #1;
   endtask

   // Waits until no transfer is outstanding on either output channel
   task automatic drain_and_check();
      @(posedge clk);
      while (enq_q.size() != 0 || resp_q.size() != 0 || task_enq_valid || m_resp_valid)
         @(posedge clk);
      #1;
      check_value("s_only_untied", count_valid() > N_ENTRIES - 3, s_only_untied);
      check_value("empty", count_valid() == 0, empty);
   endtask

   initial begin
      reg_data_t rd;
      int hits;
      seed = 32'he449445f;
      rstn = 1'b0;
      {s_wvalid, s_tied, s_wdata, s_cq_slot, s_child_id} = '0;
      {retry_valid, retry_tsb_id, retry_abort, retry_tied} = '0;
      {task_resp_valid, task_resp_ack, task_resp_tsb_id, task_resp_epoch, task_resp_tq_slot} = '0;
      {reg_wvalid, reg_waddr, reg_wdata, reg_arvalid, reg_araddr} = '0;
      task_enq_ready = 1'b1;
      m_resp_ready = 1'b1;
      for (int i = 0; i < N_ENTRIES; i++) begin
         mdl_valid[i] = 1'b0;
      end
      repeat (3) @(posedge clk);
      #1 rstn = 1'b1;
      check_value("lvt", 0, lvt);
      check_value("empty", 1, empty);
      stall_en = 1'b1;
      repeat (10) send_write(1'($random(seed)));
      drain_and_check();
      hits = 0;
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (mdl_valid[i] && hits < 2) begin
            send_retry(i, hits == 1, !mdl_tied[i]);   // Re-send first, abort second
            hits++;
         end
      end
      drain_and_check();
      reg_read(TSB_ENTRY_VALID, rd);
      for (int i = 0; i < N_ENTRIES; i++) begin
         check_value("reg_rdata entry bit", mdl_valid[i], rd[i]);
      end
      repeat (2 * N_ENTRIES + 2) @(posedge clk);
      #1 check_value("lvt", min_ts(), lvt);
      while (count_valid() < N_ENTRIES) begin
         send_write(1'($random(seed)));
         drain_and_check();
      end
      s_wvalid = 1'b1;
      repeat (5) begin
         @(posedge clk);
         check_value("s_wready", 0, s_wready);
      end
      #1 s_wvalid = 1'b0;
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (mdl_valid[i]) begin
            send_resp(i, 1'b0);
            send_resp(i, 1'b1);
         end
      end
      drain_and_check();
      repeat (2 * N_ENTRIES + 2) @(posedge clk);
      #1 check_value("lvt", 32'hffffffff, lvt);
      for (int v = 1; v >= 0; v--) begin
         reg_write(TSB_LOG_N_TILES, reg_data_t'(v));
         cur_log_n = v;
         reg_read(TSB_LOG_N_TILES, rd);
         check_value("reg_rdata", v, rd);
         repeat (3) send_write(1'($random(seed)));
         drain_and_check();
      end
      hits = n_errors + tsb_inst.props_inst.n_fail;
      $display("Checks done: %0d testbench errors, %0d property failures",
               n_errors, tsb_inst.props_inst.n_fail);
      if (hits == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/tsb_props.sv */
`timescale 1ns/1ns
`default_nettype none

module tsb_props
   import swarm_types_pkg::*;
(
   input wire logic          clk,
   input wire logic          rstn,
   input wire logic          s_wready,
   input wire logic          task_enq_valid,
   input wire logic          task_enq_ready,
   input wire task_t         task_enq_data,
   input wire tsb_entry_id_t task_enq_tsb_id,
   input wire logic          m_resp_valid,
   input wire logic          m_resp_ready,
   input wire epoch_t        m_epoch,
   input wire tsb_entry_id_t m_tsb_slot,
   input wire logic          reg_rvalid
);

   int n_fail = 0;   // Number of failed properties

   enq_held: assert property (@(posedge clk) disable iff (!rstn)
      task_enq_valid && !task_enq_ready |=>
         task_enq_valid && $stable(task_enq_data) && $stable(task_enq_tsb_id))
      else begin
         $error("Enqueue valid or data changed while the network stalled");
         n_fail++;
      end

   resp_held: assert property (@(posedge clk) disable iff (!rstn)
      m_resp_valid && !m_resp_ready |=>
         m_resp_valid && $stable(m_epoch) && $stable(m_tsb_slot))
      else begin
         $error("Child response valid or data changed while stalled");
         n_fail++;
      end

   wready_stall: assert property (@(posedge clk) disable iff (!rstn)
      task_enq_valid && !task_enq_ready |-> !s_wready)
      else begin
         $error("Write accepted while the enqueue register was stalled");
         n_fail++;
      end

   // First cycle out of reset
   reset_quiet: assert property (@(posedge clk)
      $rose(rstn) |-> !task_enq_valid && !m_resp_valid && !reg_rvalid)
      else begin
         $error("A valid output was high right after reset");
         n_fail++;
      end

endmodule

bind tsb_top tsb_props props_inst (
   .clk(clk), .rstn(rstn), .s_wready(s_wready),
   .task_enq_valid(task_enq_valid), .task_enq_ready(task_enq_ready),
   .task_enq_data(task_enq_data), .task_enq_tsb_id(task_enq_tsb_id),
   .m_resp_valid(m_resp_valid), .m_resp_ready(m_resp_ready),
   .m_epoch(m_epoch), .m_tsb_slot(m_tsb_slot), .reg_rvalid(reg_rvalid)
);

`default_nettype wire

/* src/tsb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tsb_top
   import swarm_types_pkg::*, tsb_regs_pkg::*;
#(
   parameter int LOG_TSB_SIZE = 4,
   parameter int N_TILES      = 4
) (
   input  wire logic           clk,
   input  wire logic           rstn,
   input  wire logic           s_wvalid,
   output      logic           s_wready,
   input  wire task_t          s_wdata,
   input  wire logic           s_tied,
   input  wire cq_slice_slot_t s_cq_slot,
   input  wire child_id_t      s_child_id,
   input  wire logic           retry_valid,
   output      logic           retry_ready,
   input  wire tsb_entry_id_t  retry_tsb_id,
   input  wire logic           retry_abort,
   input  wire logic           retry_tied,
   output      logic           task_enq_valid,
   input  wire logic           task_enq_ready,
   output      task_t          task_enq_data,
   output      logic           task_enq_tied,
   output      tile_id_t       task_enq_dest_tile,
   output      tsb_entry_id_t  task_enq_tsb_id,
   input  wire logic           task_resp_valid,
   output      logic           task_resp_ready,
   input  wire logic           task_resp_ack,
   input  wire tsb_entry_id_t  task_resp_tsb_id,
   input  wire epoch_t         task_resp_epoch,
   input  wire tq_slot_t       task_resp_tq_slot,
   output      logic           m_resp_valid,
   input  wire logic           m_resp_ready,
   output      logic           m_resp_ack,
   output      tsb_entry_id_t  m_tsb_slot,
   output      epoch_t         m_epoch,
   output      tq_slot_t       m_tq_slot,
   output      tile_id_t       m_tile_id,
   output      cq_slice_slot_t m_cq_slot,
   output      child_id_t      m_child_id,
   input  wire logic           reg_wvalid,
   input  wire reg_addr_t      reg_waddr,
   input  wire reg_data_t      reg_wdata,
   input  wire logic           reg_arvalid,
   input  wire reg_addr_t      reg_araddr,
   output      logic           reg_rvalid,
   output      reg_data_t      reg_rdata,
   output      logic           s_only_untied,
   output      ts_t            lvt,
   output      logic           empty
);

   logic                       wr_en;
   tsb_entry_id_t              wr_idx;
   task_t                      wr_task;
   tile_id_t                   wr_tile;
   cq_slice_slot_t             wr_cq_slot;
   child_id_t                  wr_child_id;
   logic                       tied_wr_en;
   tsb_entry_id_t              tied_wr_idx;
   logic                       tied_wr_val;
   tsb_entry_id_t              retry_idx;
   task_t                      retry_task;
   tile_id_t                   retry_tile;
   tsb_entry_id_t              resp_idx;
   logic                       resp_tied;
   tile_id_t                   resp_tile;
   cq_slice_slot_t             resp_cq_slot;
   child_id_t                  resp_child_id;
   logic [2**LOG_TSB_SIZE-1:0] entry_valid;
   tile_id_t                   dest_tile;
   tsb_entry_id_t              scan_idx;
   ts_t                        scan_ts;

   tsb_ctrl #(.LOG_TSB_SIZE(LOG_TSB_SIZE)) ctrl_inst (.*);

   tsb_entry_store #(.LOG_TSB_SIZE(LOG_TSB_SIZE)) store_inst (
      .clk, .wr_en, .wr_idx, .wr_task, .wr_tile, .wr_cq_slot, .wr_child_id,
      .tied_wr_en, .tied_wr_idx, .tied_wr_val,
      .retry_idx, .retry_task, .retry_tile,
      .resp_idx, .resp_tied, .resp_tile, .resp_cq_slot, .resp_child_id,
      .scan_idx, .scan_ts
   );

   tsb_lvt_scan #(.LOG_TSB_SIZE(LOG_TSB_SIZE)) scan_inst (
      .clk, .rstn, .entry_valid, .scan_idx, .scan_ts, .lvt
   );

   tsb_config #(.N_TILES(N_TILES), .LOG_TSB_SIZE(LOG_TSB_SIZE)) config_inst (
      .clk, .rstn, .reg_wvalid, .reg_waddr, .reg_wdata,
      .reg_arvalid, .reg_araddr, .reg_rvalid, .reg_rdata,
      .entry_valid,
      .hint      (s_wdata.hint),   // Decoded while the write is offered
      .dest_tile
   );

endmodule

`default_nettype wire

/* src/tsb_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tsb_ctrl
   import swarm_types_pkg::*;
#(
   parameter int LOG_TSB_SIZE = 4
) (
   input  wire logic                       clk,
   input  wire logic                       rstn,
   input  wire logic                       s_wvalid,
   output      logic                       s_wready,
   input  wire task_t                      s_wdata,
   input  wire logic                       s_tied,
   input  wire cq_slice_slot_t             s_cq_slot,
   input  wire child_id_t                  s_child_id,
   input  wire tile_id_t                   dest_tile,
   input  wire logic                       retry_valid,
   output      logic                       retry_ready,
   input  wire tsb_entry_id_t              retry_tsb_id,
   input  wire logic                       retry_abort,
   input  wire logic                       retry_tied,
   output      logic                       task_enq_valid,
   input  wire logic                       task_enq_ready,
   output      task_t                      task_enq_data,
   output      logic                       task_enq_tied,
   output      tile_id_t                   task_enq_dest_tile,
   output      tsb_entry_id_t              task_enq_tsb_id,
   input  wire logic                       task_resp_valid,
   output      logic                       task_resp_ready,
   input  wire logic                       task_resp_ack,
   input  wire tsb_entry_id_t              task_resp_tsb_id,
   input  wire epoch_t                     task_resp_epoch,
   input  wire tq_slot_t                   task_resp_tq_slot,
   output      logic                       m_resp_valid,
   input  wire logic                       m_resp_ready,
   output      logic                       m_resp_ack,
   output      tsb_entry_id_t              m_tsb_slot,
   output      epoch_t                     m_epoch,
   output      tq_slot_t                   m_tq_slot,
   output      tile_id_t                   m_tile_id,
   output      cq_slice_slot_t             m_cq_slot,
   output      child_id_t                  m_child_id,
   output      logic                       wr_en,
   output      tsb_entry_id_t              wr_idx,
   output      task_t                      wr_task,
   output      tile_id_t                   wr_tile,
   output      cq_slice_slot_t             wr_cq_slot,
   output      child_id_t                  wr_child_id,
   output      logic                       tied_wr_en,
   output      tsb_entry_id_t              tied_wr_idx,
   output      logic                       tied_wr_val,
   output      tsb_entry_id_t              retry_idx,
   input  wire task_t                      retry_task,
   input  wire tile_id_t                   retry_tile,
   output      tsb_entry_id_t              resp_idx,
   input  wire logic                       resp_tied,
   input  wire tile_id_t                   resp_tile,
   input  wire cq_slice_slot_t             resp_cq_slot,
   input  wire child_id_t                  resp_child_id,
   output      logic [2**LOG_TSB_SIZE-1:0] entry_valid,
   output      logic                       s_only_untied,
   output      logic                       empty
);

   localparam int N = 2**LOG_TSB_SIZE;
   localparam logic [LOG_TSB_SIZE:0] UNTIED_LIMIT = (LOG_TSB_SIZE + 1)'(N - 3);

   tsb_entry_id_t           free_idx;
   logic                    any_free;
   logic                    enq_free;
   logic                    wr_fire;
   logic                    retry_fire;
   logic                    resend;
   logic                    resp_fire;
   logic                    dec_resp;
   logic                    dec_retry;
   logic [N-1:0]            valid_next;
   logic [LOG_TSB_SIZE:0]   n_used;

   // Lowest numbered free entry wins
   always_comb begin
      free_idx = '0;
      for (int i = N - 1; i >= 0; i--) begin
         if (!entry_valid[i]) begin
            free_idx = tsb_entry_id_t'(i);
         end
      end
   end

   assign any_free   = ~&entry_valid;
   assign enq_free   = !task_enq_valid || task_enq_ready;
   assign s_wready   = enq_free && any_free;
   assign wr_fire    = s_wvalid && s_wready;
   assign retry_ready = enq_free && !wr_fire;    // Writes go first
   assign retry_fire = retry_valid && retry_ready;
   assign resend     = retry_fire && !retry_abort;

   assign task_resp_ready = !m_resp_valid;
   assign resp_fire  = task_resp_valid && task_resp_ready;
   assign dec_resp   = resp_fire && task_resp_ack;
   assign dec_retry  = retry_fire && retry_abort;

   assign wr_en       = wr_fire;
   assign wr_idx      = free_idx;
   assign wr_task     = s_wdata;
   assign wr_tile     = dest_tile;
   assign wr_cq_slot  = s_cq_slot;
   assign wr_child_id = s_child_id;
   assign tied_wr_en  = wr_fire || resend;
   assign tied_wr_idx = wr_fire ? free_idx : retry_tsb_id;
   assign tied_wr_val = wr_fire ? s_tied : retry_tied;
   assign retry_idx   = retry_tsb_id;
   assign resp_idx    = task_resp_tsb_id;

   always_comb begin
      valid_next = entry_valid;
      if (dec_retry) begin
         valid_next[retry_tsb_id[LOG_TSB_SIZE-1:0]] = 1'b0;
      end
      if (dec_resp) begin
         valid_next[task_resp_tsb_id[LOG_TSB_SIZE-1:0]] = 1'b0;
      end
      if (wr_fire) begin
         valid_next[free_idx[LOG_TSB_SIZE-1:0]] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         entry_valid <= '0;
         n_used      <= '0;
      end else begin
         entry_valid <= valid_next;
         n_used      <= n_used + {{LOG_TSB_SIZE{1'b0}}, wr_fire}
                               - {{LOG_TSB_SIZE{1'b0}}, dec_resp}
                               - {{LOG_TSB_SIZE{1'b0}}, dec_retry};
      end
   end

   assign s_only_untied = n_used > UNTIED_LIMIT;   // Only untied children may be spawned
   assign empty         = entry_valid == '0;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_enq_valid <= 1'b0;
      end else if (wr_fire || resend) begin
         task_enq_valid <= 1'b1;
      end else if (task_enq_ready) begin
         task_enq_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         task_enq_data      <= s_wdata;
         task_enq_tied      <= s_tied;
         task_enq_dest_tile <= dest_tile;
         task_enq_tsb_id    <= free_idx;
      end else if (resend) begin
         task_enq_data      <= retry_task;
         task_enq_tied      <= retry_tied;        // The tied flag may change on a retry
         task_enq_dest_tile <= retry_tile;
         task_enq_tsb_id    <= retry_tsb_id;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         m_resp_valid <= 1'b0;
      end else if (resp_fire && resp_tied) begin
         m_resp_valid <= 1'b1;
      end else if (m_resp_ready) begin
         m_resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (resp_fire && resp_tied) begin
         m_resp_ack <= task_resp_ack;
         m_tsb_slot <= task_resp_tsb_id;
         m_epoch    <= task_resp_epoch;
         m_tq_slot  <= task_resp_tq_slot;
         m_tile_id  <= resp_tile;
         m_cq_slot  <= resp_cq_slot;
         m_child_id <= resp_child_id;
      end
   end

endmodule

`default_nettype wire

/* src/tsb_lvt_scan.sv */
`timescale 1ns/1ns
`default_nettype none

module tsb_lvt_scan
   import swarm_types_pkg::*;
#(
   parameter int LOG_TSB_SIZE = 4
) (
   input  wire logic                       clk,
   input  wire logic                       rstn,
   input  wire logic [2**LOG_TSB_SIZE-1:0] entry_valid,
   output      tsb_entry_id_t              scan_idx,
   input  wire ts_t                        scan_ts,
   output      ts_t                        lvt
);

   logic [LOG_TSB_SIZE-1:0] cur_cycle;
   ts_t                     lvt_rolling;

   assign scan_idx = tsb_entry_id_t'(cur_cycle);

   // One entry is examined per cycle, so a window lasts one pass over the store
   always_ff @(posedge clk) begin
      if (!rstn) begin
         cur_cycle   <= '0;
         lvt_rolling <= '0;
         lvt         <= '0;
      end else begin
         cur_cycle <= cur_cycle + 1'b1;
         if (cur_cycle == '0) begin
            lvt         <= lvt_rolling;                     // Publish the closed window
            lvt_rolling <= entry_valid[0] ? scan_ts : '1;
         end else if (entry_valid[cur_cycle] && scan_ts < lvt_rolling) begin
            lvt_rolling <= scan_ts;
         end
      end
   end

endmodule

`default_nettype wire

/* src/tsb_entry_store.sv */
`timescale 1ns/1ns
`default_nettype none

module tsb_entry_store
   import swarm_types_pkg::*;
#(
   parameter int LOG_TSB_SIZE = 4
) (
   input  wire logic           clk,
   input  wire logic           wr_en,
   input  wire tsb_entry_id_t  wr_idx,
   input  wire task_t          wr_task,
   input  wire tile_id_t       wr_tile,
   input  wire cq_slice_slot_t wr_cq_slot,
   input  wire child_id_t      wr_child_id,
   input  wire logic           tied_wr_en,
   input  wire tsb_entry_id_t  tied_wr_idx,
   input  wire logic           tied_wr_val,
   input  wire tsb_entry_id_t  retry_idx,
   output      task_t          retry_task,
   output      tile_id_t       retry_tile,
   input  wire tsb_entry_id_t  resp_idx,
   output      logic           resp_tied,
   output      tile_id_t       resp_tile,
   output      cq_slice_slot_t resp_cq_slot,
   output      child_id_t      resp_child_id,
   input  wire tsb_entry_id_t  scan_idx,
   output      ts_t            scan_ts
);

   localparam int N = 2**LOG_TSB_SIZE;

   task_t          task_mem  [N];
   tile_id_t       tile_mem  [N];
   cq_slice_slot_t cq_mem    [N];
   child_id_t      child_mem [N];
   logic           tied_mem  [N];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         task_mem[wr_idx[LOG_TSB_SIZE-1:0]]  <= wr_task;
         tile_mem[wr_idx[LOG_TSB_SIZE-1:0]]  <= wr_tile;
         cq_mem[wr_idx[LOG_TSB_SIZE-1:0]]    <= wr_cq_slot;
         child_mem[wr_idx[LOG_TSB_SIZE-1:0]] <= wr_child_id;
      end
      // Written both on a new entry and on a retry
      if (tied_wr_en) begin
         tied_mem[tied_wr_idx[LOG_TSB_SIZE-1:0]] <= tied_wr_val;
      end
   end

   assign retry_task = task_mem[retry_idx[LOG_TSB_SIZE-1:0]];
   assign retry_tile = tile_mem[retry_idx[LOG_TSB_SIZE-1:0]];

   assign resp_tied     = tied_mem[resp_idx[LOG_TSB_SIZE-1:0]];
   assign resp_tile     = tile_mem[resp_idx[LOG_TSB_SIZE-1:0]];
   assign resp_cq_slot  = cq_mem[resp_idx[LOG_TSB_SIZE-1:0]];
   assign resp_child_id = child_mem[resp_idx[LOG_TSB_SIZE-1:0]];

   assign scan_ts = task_mem[scan_idx[LOG_TSB_SIZE-1:0]].ts;

endmodule

`default_nettype wire

/* src/tsb_config.sv */
`timescale 1ns/1ns
`default_nettype none

module tsb_config
   import swarm_types_pkg::*, tsb_regs_pkg::*;
#(
   parameter int N_TILES      = 4,
   parameter int LOG_TSB_SIZE = 4
) (
   input  wire logic                         clk,
   input  wire logic                         rstn,
   input  wire logic                         reg_wvalid,
   input  wire reg_addr_t                    reg_waddr,
   input  wire reg_data_t                    reg_wdata,
   input  wire logic                         reg_arvalid,
   input  wire reg_addr_t                    reg_araddr,
   output      logic                         reg_rvalid,
   output      reg_data_t                    reg_rdata,
   input  wire logic [2**LOG_TSB_SIZE-1:0]   entry_valid,
   input  wire hint_t                        hint,
   output      tile_id_t                     dest_tile
);

   logic [2:0] log_n_tiles;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         log_n_tiles <= 3'($clog2(N_TILES));
      end else if (reg_wvalid && reg_waddr == TSB_LOG_N_TILES) begin
         log_n_tiles <= reg_wdata[2:0];
      end
   end

   always_comb begin
      case (log_n_tiles)
         3'd0:    dest_tile = '0;                    // Single tile system
         3'd1:    dest_tile = {3'b000, hint[4]};
         3'd2:    dest_tile = {2'b00, hint[5:4]};
         3'd3:    dest_tile = {1'b0, hint[6:4]};
         default: dest_tile = hint[7:4];
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            TSB_LOG_N_TILES: reg_rdata <= reg_data_t'(log_n_tiles);
            TSB_ENTRY_VALID: reg_rdata <= reg_data_t'(entry_valid);
            default:         reg_rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/tsb_regs_pkg.sv */
`default_nettype none

package tsb_regs_pkg;

   typedef logic [7:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;

   localparam reg_addr_t TSB_LOG_N_TILES = 8'h04;  // Read and write
   localparam reg_addr_t TSB_ENTRY_VALID = 8'h08;  // Read only

endpackage

`default_nettype wire

/* src/swarm_types_pkg.sv */
`default_nettype none

package swarm_types_pkg;

   typedef logic [31:0] ts_t;
   typedef logic [15:0] hint_t;

   typedef logic [3:0] tile_id_t;
   typedef logic [3:0] tsb_entry_id_t;

   typedef logic [7:0] epoch_t;
   typedef logic [5:0] tq_slot_t;      // Slot in the destination task queue
   typedef logic [4:0] cq_slice_slot_t;
   typedef logic [1:0] child_id_t;

   // Hint bits 4 and up select the destination tile
   typedef struct packed {
      ts_t         ts;
      hint_t       hint;
      logic [15:0] payload;
   } task_t;

endpackage

`default_nettype wire
